//--- lda_pkg.sv
package lda_pkg;

    // framebuffer geometry, one cell per 8x8 screen block
    localparam int fb_w       = 80;
    localparam int fb_h       = 60;
    localparam int fb_depth   = fb_w * fb_h;      // 4800 cells
    localparam int x_bits     = 7;
    localparam int y_bits     = 6;
    localparam int addr_bits  = 13;
    localparam int color_bits = 3;                // r, g, b one bit each

    // 640x480 at 25 MHz pixel rate
    localparam int h_visible = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_back    = 48;
    localparam int h_total   = h_visible + h_front + h_sync + h_back;   // 800
    localparam int v_visible = 480;
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_back    = 33;
    localparam int v_total   = v_visible + v_front + v_sync + v_back;   // 525
    localparam int scale_shift = 3;               // 8x upscale

    // SW[9:7] field select
    localparam logic [2:0] fld_x0    = 3'd0;
    localparam logic [2:0] fld_y0    = 3'd1;
    localparam logic [2:0] fld_x1    = 3'd2;
    localparam logic [2:0] fld_y1    = 3'd3;
    localparam logic [2:0] fld_color = 3'd4;

    localparam logic [6:0] seg_blank = 7'h7f;     // segments are active low

    typedef struct packed {
        logic [x_bits-1:0]     x0;
        logic [y_bits-1:0]     y0;
        logic [x_bits-1:0]     x1;
        logic [y_bits-1:0]     y1;
        logic [color_bits-1:0] color;
    } line_cmd_t;                                 // 29 bits

    typedef struct packed {
        logic [x_bits-1:0]     x;
        logic [y_bits-1:0]     y;
        logic [color_bits-1:0] color;
    } plot_t;                                     // 16 bits

    typedef struct packed {
        logic                 hs;                 // pin level, low in sync
        logic                 vs;                 // pin level, low in sync
        logic                 blank;              // high outside visible area
        logic [addr_bits-1:0] addr;               // framebuffer read address
    } scan_t;                                     // 16 bits

    // hex digit to active-low seven-segment pattern, segment 0 = a
    function automatic logic [6:0] hex_to_seg(input logic [3:0] d);
        case (d)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;           // F
        endcase
    endfunction

endpackage

//--- lda_cmd_regs.sv
module lda_cmd_regs (
    input  logic               CLOCK_50,
    input  logic               rst_n,
    input  logic [2:1]         key,
    input  logic [9:0]         sw,
    output lda_pkg::line_cmd_t cmd,
    output logic               start,
    output logic [6:0]         hex_sel,
    output logic [6:0]         hex_hi,
    output logic [6:0]         hex_lo
);

    logic [2:1] key_s1, key_s2, key_s3;   // two-flop sync plus history
    logic [2:1] press;
    logic [2:0] fld;
    logic [6:0] val;
    logic [6:0] val_x;                    // clamped to 0..79
    logic [5:0] val_y;                    // clamped to 0..59
    logic [7:0] sel_val;                  // stored value of the selected field

    assign fld   = sw[9:7];
    assign val   = sw[6:0];
    assign val_x = (val > 7'(lda_pkg::fb_w - 1)) ? 7'(lda_pkg::fb_w - 1) : val;
    assign val_y = (val > 7'(lda_pkg::fb_h - 1)) ? 6'(lda_pkg::fb_h - 1) : val[5:0];

    // keys idle high, press is the synced 1 -> 0 edge
    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            key_s1 <= '1;
            key_s2 <= '1;
            key_s3 <= '1;
        end else begin
            key_s1 <= key;
            key_s2 <= key_s1;
            key_s3 <= key_s2;
        end
    end

    assign press = key_s3 & ~key_s2;
    assign start = press[2];              // same cycle as a KEY[1] write enable

    // field write on KEY[1], codes 5..7 fall through
    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            cmd <= '0;
        end else if (press[1]) begin
            case (fld)
                lda_pkg::fld_x0:    cmd.x0    <= val_x;
                lda_pkg::fld_y0:    cmd.y0    <= val_y;
                lda_pkg::fld_x1:    cmd.x1    <= val_x;
                lda_pkg::fld_y1:    cmd.y1    <= val_y;
                lda_pkg::fld_color: cmd.color <= val[2:0];   // low 3 bits only
                default: ;
            endcase
        end
    end

    always_comb begin
        case (fld)
            lda_pkg::fld_x0:    sel_val = {1'b0, cmd.x0};
            lda_pkg::fld_y0:    sel_val = {2'b0, cmd.y0};
            lda_pkg::fld_x1:    sel_val = {1'b0, cmd.x1};
            lda_pkg::fld_y1:    sel_val = {2'b0, cmd.y1};
            lda_pkg::fld_color: sel_val = {5'b0, cmd.color};
            default:            sel_val = 8'h00;             // unused codes show 00
        endcase
    end

    // display lags switches and registers by one cycle
    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            hex_sel <= lda_pkg::seg_blank;
            hex_hi  <= lda_pkg::seg_blank;
            hex_lo  <= lda_pkg::seg_blank;
        end else begin
            hex_sel <= lda_pkg::hex_to_seg({1'b0, fld});
            hex_hi  <= lda_pkg::hex_to_seg(sel_val[7:4]);
            hex_lo  <= lda_pkg::hex_to_seg(sel_val[3:0]);
        end
    end

endmodule

//--- lda_line_drawer.sv
module lda_line_drawer (
    input  logic               CLOCK_50,
    input  logic               rst_n,
    input  lda_pkg::line_cmd_t cmd,
    input  logic               start,
    output logic               plot,
    output lda_pkg::plot_t     pix,
    output logic               busy,
    output logic               done
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,                              // one cycle to form deltas
        st_draw,                               // one pixel per cycle
        st_done
    } state_t;

    state_t state;

    // current point and target latched on start
    logic [6:0] cur_x, end_x;
    logic [5:0] cur_y, end_y;
    logic [2:0] color;

    logic signed [9:0] dx;                     // |x1-x0|
    logic signed [9:0] dy;                     // -|y1-y0|
    logic signed [9:0] err;
    logic              sx_neg, sy_neg;         // step direction per axis

    logic signed [9:0] ddx, ddy, adx, ady;
    logic signed [9:0] e2;
    logic              step_x, step_y;
    logic              at_end;

    assign ddx = 10'(end_x) - 10'(cur_x);
    assign ddy = 10'(end_y) - 10'(cur_y);
    assign adx = (ddx < 0) ? -ddx : ddx;
    assign ady = (ddy < 0) ? -ddy : ddy;

    assign e2     = err <<< 1;
    assign step_x = (e2 >= dy);
    assign step_y = (e2 <= dx);
    assign at_end = (cur_x == end_x) && (cur_y == end_y);   // both endpoints plotted

    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle, st_done: begin
                    if (start) begin
                        state <= st_setup;
                    end
                end
                st_setup: state <= st_draw;
                st_draw: begin
                    if (at_end) begin
                        state <= st_done;            // done one cycle after last plot
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // latch on start and one Bresenham step per plot
    always_ff @(posedge CLOCK_50) begin
        if ((state == st_idle || state == st_done) && start) begin
            cur_x <= cmd.x0;
            cur_y <= cmd.y0;
            end_x <= cmd.x1;
            end_y <= cmd.y1;
            color <= cmd.color;
        end else if (state == st_setup) begin
            dx     <= adx;
            dy     <= -ady;
            err    <= adx - ady;
            sx_neg <= (ddx < 0);
            sy_neg <= (ddy < 0);
        end else if (state == st_draw && !at_end) begin
            if (step_x) begin
                cur_x <= sx_neg ? cur_x - 7'd1 : cur_x + 7'd1;
            end
            if (step_y) begin
                cur_y <= sy_neg ? cur_y - 6'd1 : cur_y + 6'd1;
            end
            err <= err + (step_x ? dy : 10'sd0) + (step_y ? dx : 10'sd0);
        end
    end

    assign plot = (state == st_draw);
    assign busy = (state == st_setup) || (state == st_draw);
    assign done = (state == st_done);
    assign pix  = '{x: cur_x, y: cur_y, color: color};

endmodule

//--- lda_vga_scan.sv
module lda_vga_scan (
    input  logic           CLOCK_50,
    input  logic           rst_n,
    output logic           pix_en,
    output lda_pkg::scan_t scan
);

    localparam int hs_start = lda_pkg::h_visible + lda_pkg::h_front;
    localparam int hs_end   = hs_start + lda_pkg::h_sync;
    localparam int vs_start = lda_pkg::v_visible + lda_pkg::v_front;
    localparam int vs_end   = vs_start + lda_pkg::v_sync;

    logic       en_q;                  // 25 MHz enable from 50 MHz
    logic [9:0] h_cnt, v_cnt;
    logic       visible;
    logic [6:0] row, col;              // framebuffer cell of this pixel

    always_ff @(posedge CLOCK_50) begin
        if (!rst_n) begin
            en_q  <= 1'b0;
            h_cnt <= '0;                   // 0,0 is first visible pixel
            v_cnt <= '0;
        end else begin
            en_q <= ~en_q;
            if (en_q) begin
                if (h_cnt == 10'(lda_pkg::h_total - 1)) begin
                    h_cnt <= '0;
                    if (v_cnt == 10'(lda_pkg::v_total - 1)) begin
                        v_cnt <= '0;
                    end else begin
                        v_cnt <= v_cnt + 10'd1;
                    end
                end else begin
                    h_cnt <= h_cnt + 10'd1;
                end
            end
        end
    end

    assign pix_en  = en_q;
    assign visible = (h_cnt < lda_pkg::h_visible) && (v_cnt < lda_pkg::v_visible);

    assign row = 7'(v_cnt >> lda_pkg::scale_shift);
    assign col = 7'(h_cnt >> lda_pkg::scale_shift);

    assign scan.hs    = !((h_cnt >= hs_start) && (h_cnt < hs_end));   // active low
    assign scan.vs    = !((v_cnt >= vs_start) && (v_cnt < vs_end));   // active low
    assign scan.blank = !visible;
    // row*80 = row*64 + row*16, parked at 0 in blanking
    assign scan.addr  = visible ? (13'(row) << 6) + (13'(row) << 4) + 13'(col) : '0;

endmodule

//--- lda_frame_display.sv
module lda_frame_display (
    input  logic           CLOCK_50,
    input  logic           pix_en,
    input  lda_pkg::scan_t scan,
    input  logic           plot,
    input  lda_pkg::plot_t pix,
    output logic [7:0]     vga_r,
    output logic [7:0]     vga_g,
    output logic [7:0]     vga_b,
    output logic           vga_hs,
    output logic           vga_vs,
    output logic           vga_blank_n,
    output logic           vga_sync_n,
    output logic           vga_clk
);

    logic [lda_pkg::color_bits-1:0] mem [lda_pkg::fb_depth];

    logic [lda_pkg::addr_bits-1:0]  wr_addr;
    logic [lda_pkg::color_bits-1:0] rd_q;

    // sync and blank registered alongside read data, idle levels at power up
    logic hs_q    = 1'b1;
    logic vs_q    = 1'b1;
    logic blank_q = 1'b1;
    logic clk_q   = 1'b0;

    initial begin
        for (int i = 0; i < lda_pkg::fb_depth; i++) begin
            mem[i] = '0;                   // screen starts black
        end
    end

    // y*80 + x
    assign wr_addr = (13'(pix.y) << 6) + (13'(pix.y) << 4) + 13'(pix.x);

    always_ff @(posedge CLOCK_50) begin
        if (plot) begin
            mem[wr_addr] <= pix.color;     // drawer never stalls
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (pix_en) begin
            rd_q    <= mem[scan.addr];
            hs_q    <= scan.hs;            // one pixel behind counters
            vs_q    <= scan.vs;
            blank_q <= scan.blank;
        end
        clk_q <= pix_en;                   // rises the cycle after each enable
    end

    // r g b bit order, blanking forces black
    assign vga_r = (rd_q[2] && !blank_q) ? 8'hff : 8'h00;
    assign vga_g = (rd_q[1] && !blank_q) ? 8'hff : 8'h00;
    assign vga_b = (rd_q[0] && !blank_q) ? 8'hff : 8'h00;

    assign vga_hs      = hs_q;
    assign vga_vs      = vs_q;
    assign vga_blank_n = !blank_q;
    assign vga_sync_n  = 1'b1;             // no sync on green
    assign vga_clk     = clk_q;

endmodule

//--- de1soc_top.sv
module de1soc_top (
    input  logic       CLOCK_50,
    output logic [6:0] HEX0,
    output logic [6:0] HEX1,
    output logic [6:0] HEX2,
    output logic [6:0] HEX3,
    output logic [6:0] HEX4,
    output logic [6:0] HEX5,
    input  logic [3:0] KEY,
    output logic [9:0] LEDR,
    input  logic [9:0] SW,
    output logic [7:0] VGA_B,
    output logic       VGA_BLANK_N,
    output logic       VGA_CLK,
    output logic [7:0] VGA_G,
    output logic       VGA_HS,
    output logic [7:0] VGA_R,
    output logic       VGA_SYNC_N,
    output logic       VGA_VS
);

    logic [1:0] por_sr = 2'b00;    // ones shift in, two-cycle power-on reset
    logic       rst_n  = 1'b0;

    lda_pkg::line_cmd_t cmd;
    lda_pkg::plot_t     pix;
    lda_pkg::scan_t     scan;
    logic start, plot, busy, done, pix_en;

    always_ff @(posedge CLOCK_50) begin
        por_sr <= {1'b1, por_sr[1]};
        rst_n  <= por_sr[0] & KEY[0];  // KEY[0] is user reset
    end

    lda_cmd_regs cmd_regs_i (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .key      (KEY[2:1]),
        .sw       (SW),
        .cmd      (cmd),
        .start    (start),
        .hex_sel  (HEX5),
        .hex_hi   (HEX1),
        .hex_lo   (HEX0)
    );

    lda_line_drawer line_drawer_i (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .cmd      (cmd),
        .start    (start),
        .plot     (plot),
        .pix      (pix),
        .busy     (busy),
        .done     (done)
    );

    lda_vga_scan vga_scan_i (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .pix_en   (pix_en),
        .scan     (scan)
    );

    lda_frame_display frame_display_i (
        .CLOCK_50    (CLOCK_50),
        .pix_en      (pix_en),
        .scan        (scan),
        .plot        (plot),
        .pix         (pix),
        .vga_r       (VGA_R),
        .vga_g       (VGA_G),
        .vga_b       (VGA_B),
        .vga_hs      (VGA_HS),
        .vga_vs      (VGA_VS),
        .vga_blank_n (VGA_BLANK_N),
        .vga_sync_n  (VGA_SYNC_N),
        .vga_clk     (VGA_CLK)
    );

    assign LEDR = {cmd.color, 5'b0, done, busy};   // stored colour on the top three
    assign HEX2 = lda_pkg::seg_blank;
    assign HEX3 = lda_pkg::seg_blank;
    assign HEX4 = lda_pkg::seg_blank;

endmodule

//--- lda_props.sv
module lda_props (
    input logic           CLOCK_50,
    input logic           rst_n,
    input logic           start,
    input logic           plot,
    input lda_pkg::plot_t pix,
    input logic           busy,
    input logic           done
);

    int unsigned fail_cnt = 0;    // failed assertion count

    // every plotted pixel belongs to a running line
    plot_in_busy: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        plot |-> busy)
        else begin
            fail_cnt++;
            $error("plot strobe seen while the drawer was not busy");
        end

    done_busy_excl: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        !(done && busy))
        else begin
            fail_cnt++;
            $error("done and busy high together");
        end

    // write address must stay inside the 80x60 buffer
    plot_in_frame: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        plot |-> (pix.x < 7'(lda_pkg::fb_w)) && (pix.y < 6'(lda_pkg::fb_h)))
        else begin
            fail_cnt++;
            $error("plot outside the frame at x=%0d y=%0d", pix.x, pix.y);
        end

    start_to_busy: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        (start && !busy) |=> busy)     // setup cycle already counts as busy
        else begin
            fail_cnt++;
            $error("start while idle did not raise busy");
        end

endmodule

bind lda_line_drawer lda_props props_i (
    .CLOCK_50 (CLOCK_50),
    .rst_n    (rst_n),
    .start    (start),
    .plot     (plot),
    .pix      (pix),
    .busy     (busy),
    .done     (done)
);

//--- tb_de1soc.sv
module tb_de1soc;

    logic       CLOCK_50 = 1'b0;
    logic [3:0] KEY;
    logic [9:0] SW;
    logic [6:0] HEX0, HEX1, HEX2, HEX3, HEX4, HEX5;
    logic [9:0] LEDR;
    logic [7:0] VGA_R, VGA_G, VGA_B;
    logic       VGA_HS, VGA_VS, VGA_BLANK_N, VGA_SYNC_N, VGA_CLK;

    int          errors = 0;
    int          cycles = 0;
    logic [2:0]  model [4800];        // reference framebuffer indexed y*80+x

    // reset and per-row presses and draws then up to three frames for the capture
    int cycle_limit = 10 + 8 * (81 + 3 + 10) + (8 * 7 + 8) * (20 + 10)
                      + 3 * 2 * lda_pkg::h_total * lda_pkg::v_total;

    // x0 y0 x1 y1 colour as set on SW[6:0]
    int raw_tab [8][5] = '{
        '{0, 0, 120, 70, 7},          // long shallow +x +y line with clamped end
        '{70, 5, 10, 30, 3},          // shallow -x +y
        '{40, 55, 30, 2, 5},          // steep -x -y
        '{5, 50, 25, 10, 6},          // steep +x -y
        '{75, 10, 60, 58, 12},        // steep -x +y
        '{50, 40, 50, 40, 122},       // single point
        '{127, 20, 0, 20, 1},         // horizontal
        '{33, 127, 33, 0, 102}        // vertical
    };
    // stored values after clamping and colour masking
    int exp_tab [8][5] = '{
        '{0, 0, 79, 59, 7},
        '{70, 5, 10, 30, 3},
        '{40, 55, 30, 2, 5},
        '{5, 50, 25, 10, 6},
        '{75, 10, 60, 58, 4},
        '{50, 40, 50, 40, 2},
        '{79, 20, 0, 20, 1},
        '{33, 59, 33, 0, 6}
    };

    de1soc_top dut_i (.*);

    always #4 CLOCK_50 = ~CLOCK_50;

    // run limit
    always @(posedge CLOCK_50) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Run timed out after %0d cycles before all checks finished", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // active-low segments with bit 0 as a
    function automatic logic [6:0] seg_of(input int d);
        logic [6:0] segs [16];
        segs = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};
        return segs[d & 15];
    endfunction

    task automatic wait_gap();
        int gap;
        gap = 4 + int'($urandom % 17);    // 4..20 cycles
        repeat (gap) @(posedge CLOCK_50);
    endtask

    task automatic press_key(input int k);
        @(posedge CLOCK_50);
        KEY[k] <= 1'b0;
        repeat (2) @(posedge CLOCK_50);
        KEY[k] <= 1'b1;
    endtask

    task automatic check_display(input int fld, input int val);
        @(negedge CLOCK_50);
        assert (HEX5 == seg_of(fld) && HEX1 == seg_of(val >> 4) && HEX0 == seg_of(val))
        else begin
            errors++;
            $display("Error at %0t: field %0d shows %h %h %h, expected value %0d",
                     $time, fld, HEX5, HEX1, HEX0, val);
        end
    endtask

    task automatic write_field(input int fld, input int raw, input int val);
        @(posedge CLOCK_50);
        SW <= {3'(fld), 7'(raw)};
        press_key(1);
        wait_gap();
        check_display(fld, val);
    endtask

    // codes 5..7 must leave all five fields alone
    task automatic check_unused_codes(input int r);
        for (int f = 5; f < 8; f++) begin
            @(posedge CLOCK_50);
            SW <= {3'(f), 7'h15};
            press_key(1);
            wait_gap();
        end
        for (int f = 0; f < 5; f++) begin
            @(posedge CLOCK_50);
            SW <= {3'(f), 7'h00};
            repeat (2) @(posedge CLOCK_50);
            check_display(f, exp_tab[r][f]);
        end
    endtask

    // integer Bresenham over both endpoints that returns the plot count
    task automatic model_line(input int x0, input int y0, input int x1, input int y1,
                              input int c, output int n);
        int dx, dy, sx, sy, err, e2, x, y;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;     // kept negative
        sx  = (x0 < x1) ? 1 : -1;
        sy  = (y0 < y1) ? 1 : -1;
        err = dx + dy;
        x   = x0;
        y   = y0;
        n   = 0;
        forever begin
            model[y * lda_pkg::fb_w + x] = 3'(c);
            n++;
            if (x == x1 && y == y1) break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += sy;
            end
        end
    endtask

    task automatic draw_row(input int r);
        int   n, t, busy_cycles;
        logic seen_busy;
        model_line(exp_tab[r][0], exp_tab[r][1], exp_tab[r][2], exp_tab[r][3],
                   exp_tab[r][4], n);
        t           = 0;
        busy_cycles = 0;
        seen_busy   = 1'b0;
        while (!(seen_busy && LEDR[1]) && t < 81 + 3 + 10) begin
            @(posedge CLOCK_50);
            // row 0 gets a second press in the middle of the line
            KEY[2] <= !(t < 2 || (r == 0 && t >= 9 && t < 11));
            @(negedge CLOCK_50);
            if (LEDR[0]) busy_cycles++;
            seen_busy = seen_busy | LEDR[0];
            t++;
        end
        assert (seen_busy && LEDR[1] && !LEDR[0])
        else begin
            errors++;
            $display("Row %0d never finished drawing: busy seen %0b, done %0b",
                     r, seen_busy, LEDR[1]);
        end
        assert (busy_cycles == n + 1)                // setup cycle plus one per plot
        else begin
            errors++;
            $display("Error at %0t: row %0d busy for %0d cycles, expected %0d",
                     $time, r, busy_cycles, n + 1);
        end
        assert (LEDR[9:7] == 3'(exp_tab[r][4]))
        else begin
            errors++;
            $display("Error at %0t: LEDR colour %0d, expected %0d",
                     $time, LEDR[9:7], exp_tab[r][4]);
        end
        wait_gap();
    endtask

    task automatic next_pixel();
        do begin
            @(negedge CLOCK_50);
        end while (!VGA_CLK);            // high for one cycle per new pixel
    endtask

    task automatic check_frame();
        int         k, h, v;
        logic       vis, exp_hs, exp_vs, vs_prev;
        logic [2:0] exp_c;
        next_pixel();
        vs_prev = VGA_VS;
        next_pixel();
        while (!(vs_prev && !VGA_VS)) begin
            vs_prev = VGA_VS;
            next_pixel();
        end
        // pixel 0 is h=0 on the first vsync line
        for (k = 0; k < lda_pkg::h_total * lda_pkg::v_total; k++) begin
            if (k > 0) next_pixel();
            h      = k % lda_pkg::h_total;
            v      = (lda_pkg::v_visible + lda_pkg::v_front + k / lda_pkg::h_total)
                     % lda_pkg::v_total;
            vis    = (h < lda_pkg::h_visible) && (v < lda_pkg::v_visible);
            exp_c  = vis ? model[(v >> 3) * lda_pkg::fb_w + (h >> 3)] : 3'b000;
            exp_hs = !(h >= lda_pkg::h_visible + lda_pkg::h_front
                       && h < lda_pkg::h_visible + lda_pkg::h_front + lda_pkg::h_sync);
            exp_vs = !(v >= lda_pkg::v_visible + lda_pkg::v_front
                       && v < lda_pkg::v_visible + lda_pkg::v_front + lda_pkg::v_sync);
            assert (VGA_R == {8{exp_c[2]}} && VGA_G == {8{exp_c[1]}}
                    && VGA_B == {8{exp_c[0]}} && VGA_BLANK_N == vis)
            else begin
                errors++;
                $display("Error at %0t: pixel %0d,%0d rgb %h %h %h blank_n %0b, expected %0d",
                         $time, h, v, VGA_R, VGA_G, VGA_B, VGA_BLANK_N, exp_c);
            end
            assert (VGA_BLANK_N || (VGA_R | VGA_G | VGA_B) == 8'h00)
            else begin
                errors++;
                $display("Error at %0t: colour driven during blanking at %0d,%0d", $time, h, v);
            end
            assert (VGA_HS == exp_hs && VGA_VS == exp_vs && VGA_SYNC_N)
            else begin
                errors++;
                $display("Error at %0t: sync at %0d,%0d hs %0b vs %0b, expected %0b %0b",
                         $time, h, v, VGA_HS, VGA_VS, exp_hs, exp_vs);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h059c_98e5));
        KEY      = 4'b1110;              // user reset held
        SW       = '0;
        for (int i = 0; i < lda_pkg::fb_depth; i++) begin
            model[i] = 3'b000;
        end
        repeat (10) @(posedge CLOCK_50);
        KEY[0] <= 1'b1;
        repeat (4) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        assert (LEDR == 10'h000 && HEX2 == 7'h7f && HEX3 == 7'h7f && HEX4 == 7'h7f)
        else begin
            errors++;
            $display("Error at %0t: after reset LEDR %h, HEX2..4 %h %h %h",
                     $time, LEDR, HEX2, HEX3, HEX4);
        end
        for (int r = 0; r < 8; r++) begin
            for (int f = 0; f < 5; f++) begin
                write_field(f, raw_tab[r][f], exp_tab[r][f]);
            end
            if (r == 0) check_unused_codes(r);
            draw_row(r);
        end
        check_frame();
        $display("Errors: %0d check, %0d assertion", errors,
                 dut_i.line_drawer_i.props_i.fail_cnt);
        if (errors == 0 && dut_i.line_drawer_i.props_i.fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- lda.f
lda_pkg.sv
lda_cmd_regs.sv
lda_line_drawer.sv
lda_vga_scan.sv
lda_frame_display.sv
de1soc_top.sv
lda_props.sv
tb_de1soc.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_de1soc
FILELIST  = lda.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
